/* rtl/address_decoder.sv */
`timescale 1ns/1ps

module address_decoder (
    input  logic [15:0]        cpu_addr_i,
    output pet_pkg::dev_sel_e  dev_o,
    output logic [15:0]        mem_addr_o   // RAM address after VRAM mirroring
);

    logic       in_vram;   // $8000-$8FFF
    logic       in_io;     // $E800-$E8FF
    logic       in_rom;    // Write-protected space
    logic [15:0] block;    // Address of the 16-byte chip window

    assign in_vram = (cpu_addr_i >= pet_pkg::VRAM_BASE) && (cpu_addr_i <= pet_pkg::VRAM_LIMIT);
    assign in_io   = (cpu_addr_i >= pet_pkg::IO_BASE) && (cpu_addr_i <= pet_pkg::IO_LIMIT);
    assign in_rom  = (cpu_addr_i >= pet_pkg::ROM_BASE) && !in_io;
    assign block   = cpu_addr_i & pet_pkg::DEV_BLOCK_MASK;

    always_comb begin
        if (in_io) begin
            if (block == pet_pkg::PIA1_BASE) begin
                dev_o = pet_pkg::DEV_PIA1;     // Keyboard PIA
            end else if (block == pet_pkg::PIA2_BASE) begin
                dev_o = pet_pkg::DEV_PIA2;
            end else if (block == pet_pkg::VIA_BASE) begin
                dev_o = pet_pkg::DEV_VIA;
            end else begin
                dev_o = pet_pkg::DEV_IO_OTHER; // Rest of the I/O page
            end
        end else if (in_vram) begin
            dev_o = pet_pkg::DEV_VRAM;
        end else if (in_rom) begin
            dev_o = pet_pkg::DEV_ROM;
        end else begin
            dev_o = pet_pkg::DEV_RAM;
        end
    end

    // 40-column PET has 1 KB of video RAM, seen four times across the window
    always_comb begin
        if (in_vram) begin
            mem_addr_o = {cpu_addr_i[15:12], 2'b00, cpu_addr_i[9:0]};
        end else begin
            mem_addr_o = cpu_addr_i;
        end
    end

endmodule

/* rtl/bus_timing.sv */
`timescale 1ns/1ps

module bus_timing (
    input  logic               clk_bus_i,     // One tick per bus phase
    input  logic               reset_i,
    input  logic               pi_valid_i,    // Single-cycle host strobe
    input  logic [16:0]        pi_addr_i,     // Bit 16 selects register space
    input  logic [7:0]         pi_data_i,
    input  logic               pi_rw_ni,      // 1 = host read, 0 = host write
    output logic               pi_done_o,     // Pulses in phase 2
    output logic [7:0]         pi_rd_data_o,  // Valid with pi_done_o
    input  logic [15:0]        cpu_addr_i,
    input  logic               cpu_rw_ni,     // 1 = CPU read, 0 = CPU write
    input  logic [7:0]         cpu_data_i,
    output logic [7:0]         cpu_data_o,
    output logic               clk_cpu_o,     // Phi2, high in phases 4 to 7
    input  pet_pkg::dev_sel_e  dev_i,
    input  logic [15:0]        mem_addr_i,    // Mirrored RAM address for the CPU
    input  logic               kbd_hit_i,
    input  logic [7:0]         kbd_data_i,
    input  logic [7:0]         io_data_i,
    input  logic [7:0]         ctrl_rd_i,
    output logic               reg_wr_o,
    output logic [3:0]         reg_addr_o,
    output logic [7:0]         reg_data_o,
    output logic               pia1_cs_o,
    output logic               pia2_cs_o,
    output logic               via_cs_o,
    pet_mem_if.arbiter         mem
);

    pet_pkg::phase_t    phase_q;       // Position within the CPU cycle
    pet_pkg::bus_slot_e slot;          // Owner of the current phase
    logic               pending_q;     // Host request waiting for its slot
    logic [16:0]        pi_addr_q;
    logic [7:0]         pi_data_q;
    logic               pi_rw_q;
    logic               cpu_ram_dev;   // CPU address is backed by RAM
    logic               cpu_rd_q;      // Committed CPU access was a read
    logic               cpu_rd_ram_q;  // Read data comes from RAM
    logic [7:0]         cpu_alt_q;     // Keyboard or I/O byte held for phase 0

    assign clk_cpu_o   = (phase_q >= pet_pkg::CPU_CLK_HIGH_PHASE);
    assign cpu_ram_dev = dev_i inside {pet_pkg::DEV_RAM, pet_pkg::DEV_VRAM, pet_pkg::DEV_ROM};

    always_comb begin
        if (pending_q && (phase_q == pet_pkg::PI_SLOT_PHASE)) begin
            slot = pet_pkg::SLOT_PI;
        end else if (phase_q == pet_pkg::CPU_SLOT_PHASE) begin
            slot = pet_pkg::SLOT_CPU;
        end else begin
            slot = pet_pkg::SLOT_IDLE;
        end
    end

    // RAM port and register write mux
    always_comb begin
        mem.en      = 1'b0;
        mem.we      = 1'b0;
        mem.addr    = pi_addr_q[15:0];
        mem.wr_data = pi_data_q;
        reg_wr_o    = 1'b0;
        case (slot)
            pet_pkg::SLOT_PI: begin
                if (!pi_addr_q[16]) begin
                    mem.en = 1'b1;          // Host may write ROM space too
                    mem.we = !pi_rw_q;
                end else begin
                    reg_wr_o = !pi_rw_q;    // Register reads need no strobe
                end
            end
            pet_pkg::SLOT_CPU: begin
                mem.addr    = mem_addr_i;
                mem.wr_data = cpu_data_i;
                mem.en      = cpu_ram_dev;
                mem.we      = cpu_ram_dev && !cpu_rw_ni && (dev_i != pet_pkg::DEV_ROM);
            end
            default: begin
            end
        endcase
    end

    assign reg_addr_o = pi_addr_q[3:0];
    assign reg_data_o = pi_data_q;

    // Register space reads back zero except the control register
    assign pi_rd_data_o = !pi_addr_q[16] ? mem.rd_data :
                          (pi_addr_q[3:0] == pet_pkg::REG_CTRL_OFFSET) ? ctrl_rd_i : 8'h00;

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            phase_q   <= '0;
            pending_q <= 1'b0;
            pi_done_o <= 1'b0;
            cpu_rd_q  <= 1'b0;
        end else begin
            phase_q   <= phase_q + 1'b1;                 // Wraps after phase 7
            pi_done_o <= (slot == pet_pkg::SLOT_PI);     // Read data arrives in phase 2
            if (slot == pet_pkg::SLOT_PI) begin
                pending_q <= 1'b0;
            end else if (pi_valid_i) begin
                pending_q <= 1'b1;
            end
            if (slot == pet_pkg::SLOT_CPU) begin
                cpu_rd_q <= cpu_rw_ni;
            end else if (phase_q == pet_pkg::CPU_DATA_PHASE) begin
                cpu_rd_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (pi_valid_i && !pending_q) begin
            pi_addr_q <= pi_addr_i;
            pi_data_q <= pi_data_i;
            pi_rw_q   <= pi_rw_ni;
        end
        if (slot == pet_pkg::SLOT_CPU) begin
            cpu_rd_ram_q <= cpu_ram_dev && !kbd_hit_i;
            cpu_alt_q    <= kbd_hit_i ? kbd_data_i : io_data_i;  // I/O sampled at commit
        end
        if (cpu_rd_q && (phase_q == pet_pkg::CPU_DATA_PHASE)) begin
            cpu_data_o <= cpu_rd_ram_q ? mem.rd_data : cpu_alt_q;
        end
    end

    // Chip selects follow phi2, keyboard hides PIA1 port B
    assign pia1_cs_o = clk_cpu_o && (dev_i == pet_pkg::DEV_PIA1) && !kbd_hit_i;
    assign pia2_cs_o = clk_cpu_o && (dev_i == pet_pkg::DEV_PIA2);
    assign via_cs_o  = clk_cpu_o && (dev_i == pet_pkg::DEV_VIA);

    // Host must wait for pi_done_o before the next strobe
    a_no_strobe_pending: assert property (@(posedge clk_bus_i) disable iff (reset_i)
        pi_valid_i |-> !pending_q)
        else $error("host strobe while a request is pending");

    // Host and CPU slots never sit next to each other
    a_mem_en_spaced: assert property (@(posedge clk_bus_i) disable iff (reset_i)
        mem.en |=> !mem.en)
        else $error("RAM enabled in two consecutive phases");

endmodule

/* rtl/keyboard_matrix.sv */
`timescale 1ns/1ps

module keyboard_matrix (
    input  logic               clk_bus_i,
    input  logic               reset_i,
    input  logic               reg_wr_i,       // Host register write
    input  logic [3:0]         reg_addr_i,     // Row number for host writes
    input  logic [7:0]         reg_data_i,     // Row bits with 0 for a key down
    input  logic [1:0]         cpu_addr_i,     // PIA register offset
    input  logic               cpu_rw_ni,
    input  logic [7:0]         cpu_data_i,
    input  pet_pkg::dev_sel_e  dev_i,
    input  logic               cpu_commit_i,   // CPU bus data valid
    output logic               kbd_hit_o,      // CPU is reading port B
    output logic [7:0]         kbd_data_o
);

    logic [7:0] rows_q [pet_pkg::KBD_ROWS];  // Matrix state from the host
    logic [3:0] row_sel_q;                   // Last row written to port A
    logic       row_wr;
    logic       sel_wr;

    assign row_wr = reg_wr_i && (reg_addr_i < 4'(pet_pkg::KBD_ROWS));
    assign sel_wr = cpu_commit_i
                 && (dev_i == pet_pkg::DEV_PIA1)
                 && !cpu_rw_ni
                 && (cpu_addr_i == pet_pkg::PIA_PORT_A);

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            for (int i = 0; i < pet_pkg::KBD_ROWS; i++) begin
                rows_q[i] <= 8'hFF;                  // No key pressed
            end
            row_sel_q <= 4'd0;
        end else begin
            if (row_wr) begin
                rows_q[reg_addr_i] <= reg_data_i;
            end
            if (sel_wr) begin
                row_sel_q <= cpu_data_i[3:0];        // Upper bits drive other PIA lines
            end
        end
    end

    // Intercept every CPU read of port B
    assign kbd_hit_o = (dev_i == pet_pkg::DEV_PIA1)
                    && cpu_rw_ni
                    && (cpu_addr_i == pet_pkg::PIA_PORT_B);

    always_comb begin
        if (row_sel_q < 4'(pet_pkg::KBD_ROWS)) begin
            kbd_data_o = rows_q[row_sel_q];
        end else begin
            kbd_data_o = 8'hFF;                      // Unused select lines
        end
    end

endmodule

/* rtl/pet_bus_top.sv */
`timescale 1ns/1ps

module pet_bus_top (
    input  logic         clk_bus_i,
    input  logic         reset_i,
    input  logic         pi_valid_i,
    input  logic [16:0]  pi_addr_i,
    input  logic [7:0]   pi_data_i,
    input  logic         pi_rw_ni,
    output logic         pi_done_o,
    output logic [7:0]   pi_rd_data_o,
    input  logic [15:0]  cpu_addr_i,
    input  logic         cpu_rw_ni,
    input  logic [7:0]   cpu_data_i,
    output logic [7:0]   cpu_data_o,
    input  logic [7:0]   io_data_i,      // Read data from PIA and VIA chips
    output logic         pia1_cs_o,
    output logic         pia2_cs_o,
    output logic         via_cs_o,
    output logic         clk_cpu_o,
    output logic         cpu_res_o,
    output logic         cpu_ready_o
);

    pet_pkg::dev_sel_e dev;
    logic [15:0]       mem_addr;       // CPU address after mirroring
    logic              kbd_hit;
    logic [7:0]        kbd_data;
    logic [7:0]        ctrl_rd;
    logic              reg_wr;
    logic [3:0]        reg_addr;
    logic [7:0]        reg_data;

    pet_mem_if mem_if ();

    bus_timing i_bus_timing (
        .clk_bus_i    (clk_bus_i),
        .reset_i      (reset_i),
        .pi_valid_i   (pi_valid_i),
        .pi_addr_i    (pi_addr_i),
        .pi_data_i    (pi_data_i),
        .pi_rw_ni     (pi_rw_ni),
        .pi_done_o    (pi_done_o),
        .pi_rd_data_o (pi_rd_data_o),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_rw_ni    (cpu_rw_ni),
        .cpu_data_i   (cpu_data_i),
        .cpu_data_o   (cpu_data_o),
        .clk_cpu_o    (clk_cpu_o),
        .dev_i        (dev),
        .mem_addr_i   (mem_addr),
        .kbd_hit_i    (kbd_hit),
        .kbd_data_i   (kbd_data),
        .io_data_i    (io_data_i),
        .ctrl_rd_i    (ctrl_rd),
        .reg_wr_o     (reg_wr),
        .reg_addr_o   (reg_addr),
        .reg_data_o   (reg_data),
        .pia1_cs_o    (pia1_cs_o),
        .pia2_cs_o    (pia2_cs_o),
        .via_cs_o     (via_cs_o),
        .mem          (mem_if)
    );

    address_decoder i_address_decoder (
        .cpu_addr_i (cpu_addr_i),
        .dev_o      (dev),
        .mem_addr_o (mem_addr)
    );

    // Row select is latched while phi2 is high, like the PIA itself
    keyboard_matrix i_keyboard_matrix (
        .clk_bus_i    (clk_bus_i),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr),
        .reg_addr_i   (reg_addr),
        .reg_data_i   (reg_data),
        .cpu_addr_i   (cpu_addr_i[1:0]),
        .cpu_rw_ni    (cpu_rw_ni),
        .cpu_data_i   (cpu_data_i),
        .dev_i        (dev),
        .cpu_commit_i (clk_cpu_o),
        .kbd_hit_o    (kbd_hit),
        .kbd_data_o   (kbd_data)
    );

    pi_control_regs i_pi_control_regs (
        .clk_bus_i   (clk_bus_i),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr),
        .reg_addr_i  (reg_addr),
        .reg_data_i  (reg_data),
        .cpu_res_o   (cpu_res_o),
        .cpu_ready_o (cpu_ready_o),
        .ctrl_rd_o   (ctrl_rd)
    );

    system_ram i_system_ram (
        .clk_bus_i (clk_bus_i),
        .mem       (mem_if)
    );

endmodule

/* rtl/pet_mem_if.sv */
`timescale 1ns/1ps

interface pet_mem_if;

    logic        en;       // One access per strobe
    logic        we;       // 1 = write, 0 = read
    logic [15:0] addr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;  // Registered, valid the cycle after en

    modport arbiter (
        output en,
        output we,
        output addr,
        output wr_data,
        input  rd_data
    );

    modport ram (
        input  en,
        input  we,
        input  addr,
        input  wr_data,
        output rd_data
    );

endinterface

/* rtl/pet_pkg.sv */
package pet_pkg;

    // Bus cycle, one CPU cycle is eight bus clocks
    localparam int CYCLE_PHASES = 8;
    localparam int PHASE_W      = $clog2(CYCLE_PHASES);

    typedef logic [PHASE_W-1:0] phase_t;

    localparam phase_t PI_SLOT_PHASE      = 3'd1;  // Host access runs here
    localparam phase_t CPU_SLOT_PHASE     = 3'd7;  // CPU access commits here
    localparam phase_t CPU_CLK_HIGH_PHASE = 3'd4;  // First phase with clk_cpu high
    localparam phase_t CPU_DATA_PHASE     = 3'd0;  // CPU read data lands at end of this phase

    // Memory map
    localparam logic [15:0] VRAM_BASE       = 16'h8000;
    localparam logic [15:0] VRAM_LIMIT      = 16'h8FFF;
    localparam logic [15:0] ROM_BASE        = 16'h9000;
    localparam logic [15:0] IO_BASE         = 16'hE800;
    localparam logic [15:0] IO_LIMIT        = 16'hE8FF;
    localparam logic [15:0] PIA1_BASE       = 16'hE810;
    localparam logic [15:0] PIA2_BASE       = 16'hE820;
    localparam logic [15:0] VIA_BASE        = 16'hE840;
    localparam logic [15:0] DEV_BLOCK_MASK  = 16'hFFF0;  // Each chip decodes 16 bytes
    localparam int          RAM_DEPTH       = 65536;

    // PIA register offsets
    localparam logic [1:0] PIA_PORT_A = 2'd0;  // Keyboard row select
    localparam logic [1:0] PIA_PORT_B = 2'd2;  // Keyboard column read

    // Host register space
    localparam int         KBD_ROWS        = 10;
    localparam logic [3:0] REG_CTRL_OFFSET = 4'hF;
    localparam logic [7:0] CTRL_RESET_VAL  = 8'h01;  // CPU in reset, not ready
    localparam int         CTRL_RES_BIT    = 0;
    localparam int         CTRL_READY_BIT  = 1;

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_PI,
        SLOT_CPU
    } bus_slot_e;

    typedef enum logic [2:0] {
        DEV_RAM,
        DEV_VRAM,
        DEV_ROM,
        DEV_PIA1,
        DEV_PIA2,
        DEV_VIA,
        DEV_IO_OTHER
    } dev_sel_e;

endpackage

/* rtl/pi_control_regs.sv */
`timescale 1ns/1ps

module pi_control_regs (
    input  logic        clk_bus_i,
    input  logic        reset_i,
    input  logic        reg_wr_i,
    input  logic [3:0]  reg_addr_i,
    input  logic [7:0]  reg_data_i,
    output logic        cpu_res_o,     // 1 = CPU held in reset
    output logic        cpu_ready_o,   // 0 = CPU halted
    output logic [7:0]  ctrl_rd_o      // Readback for the host
);

    logic [7:0] ctrl_q;
    logic       ctrl_wr;

    assign ctrl_wr = reg_wr_i && (reg_addr_i == pet_pkg::REG_CTRL_OFFSET);

    always_ff @(posedge clk_bus_i) begin
        if (reset_i) begin
            ctrl_q <= pet_pkg::CTRL_RESET_VAL;   // Hold CPU until the host releases it
        end else if (ctrl_wr) begin
            ctrl_q <= reg_data_i;                // Spare bits kept for readback
        end
    end

    assign cpu_res_o   = ctrl_q[pet_pkg::CTRL_RES_BIT];
    assign cpu_ready_o = ctrl_q[pet_pkg::CTRL_READY_BIT];
    assign ctrl_rd_o   = ctrl_q;

endmodule

/* rtl/system_ram.sv */
`timescale 1ns/1ps

module system_ram (
    input  logic     clk_bus_i,
    pet_mem_if.ram   mem
);

    logic [7:0] ram_q [pet_pkg::RAM_DEPTH];  // Full 64 KB, ROM images included

    // Read data only changes on a read strobe
    always_ff @(posedge clk_bus_i) begin
        if (mem.en) begin
            if (mem.we) begin
                ram_q[mem.addr] <= mem.wr_data;
            end else begin
                mem.rd_data <= ram_q[mem.addr];
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the PET bus arbiter testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module tb_pet_bus \
    --Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vtb_pet_bus" | tee "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"

/* sim.f */
rtl/pet_pkg.sv
rtl/pet_mem_if.sv
rtl/address_decoder.sv
rtl/keyboard_matrix.sv
rtl/pi_control_regs.sv
rtl/system_ram.sv
rtl/bus_timing.sv
rtl/pet_bus_top.sv
testbench/tb_pet_bus.sv

/* testbench/tb_pet_bus.sv */
`timescale 1ns/1ps

module tb_pet_bus;

    localparam int N_RAM      = 32;  // Host write and read pairs
    localparam int N_CPU_RAM  = 8;   // CPU write rounds in RAM and ROM each
    localparam int N_SEL      = 12;  // Row selects up to two past the last row
    localparam int HOST_OPS   = 2 + 2 * N_RAM + 3 * N_CPU_RAM + 1 + pet_pkg::KBD_ROWS;
    localparam int CPU_OPS    = 2 * N_CPU_RAM + 2 + 8 + 2 * N_SEL;
    // A CPU access spans two CPU cycles, so it weighs as two operations
    localparam int TIMEOUT_NS = (HOST_OPS + 2 * CPU_OPS) * 9 * 8 * 2;
    localparam logic [15:0] IO_ADDRS [4] = '{16'hE811, 16'hE823, 16'hE84C, 16'hE800};

    logic        clk_bus_i, reset_i;
    logic        pi_valid_i, pi_rw_ni, pi_done_o;
    logic [16:0] pi_addr_i;
    logic [7:0]  pi_data_i, pi_rd_data_o;
    logic [15:0] cpu_addr_i;
    logic        cpu_rw_ni;
    logic [7:0]  cpu_data_i, cpu_data_o, io_data_i;
    logic        pia1_cs_o, pia2_cs_o, via_cs_o;
    logic        clk_cpu_o, cpu_res_o, cpu_ready_o;

    logic [7:0]  shadow [65536];          // Expected RAM contents
    logic [7:0]  rows [pet_pkg::KBD_ROWS];
    logic [3:0]  row_sel;
    logic [7:0]  ctrl;                    // Expected control register
    logic [7:0]  host_exp;                // Expected byte of the host read in flight
    logic        host_chk;
    string       host_msg;
    int          phase;                   // Bus phase counted from reset
    integer      seed;
    int          errors, checks;

    pet_bus_top i_dut (.*);

    function automatic logic in_io(input logic [15:0] addr);
        return addr >= pet_pkg::IO_BASE && addr <= pet_pkg::IO_LIMIT;
    endfunction

    function automatic logic [15:0] vram_mirror(input logic [15:0] addr);
        if (addr >= pet_pkg::VRAM_BASE && addr <= pet_pkg::VRAM_LIMIT) begin
            return addr & ~16'h0C00;                 // 1 KB seen four times
        end
        return addr;
    endfunction

    // CPU read reference with keyboard before I/O before RAM
    function automatic logic [7:0] cpu_read_value(input logic [15:0] addr, input logic [7:0] io);
        if ((addr & 16'hFFF0) == pet_pkg::PIA1_BASE && addr[1:0] == 2'd2) begin
            return (row_sel < 4'(pet_pkg::KBD_ROWS)) ? rows[row_sel] : 8'hFF;
        end else if (in_io(addr)) begin
            return io;
        end
        return shadow[vram_mirror(addr)];
    endfunction

    function automatic logic [7:0] host_read_value(input logic [16:0] addr);
        if (!addr[16]) begin
            return shadow[addr[15:0]];
        end
        return (addr[3:0] == pet_pkg::REG_CTRL_OFFSET) ? ctrl : 8'h00;
    endfunction

    // Expected {pia1, pia2, via} while phi2 is high
    function automatic logic [2:0] chip_select_map(input logic [15:0] addr, input logic rw_n);
        logic [15:0] blk;
        blk = addr & 16'hFFF0;
        return {blk == pet_pkg::PIA1_BASE && !(rw_n && addr[1:0] == 2'd2),
                blk == pet_pkg::PIA2_BASE,
                blk == pet_pkg::VIA_BASE};
    endfunction

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0d ns: %s, got %02h, expected %02h", $time, msg, actual, expected);
        end
    endtask

    // Strobe one host request and wait for its done pulse
    task automatic host_access(input logic [16:0] addr, input logic rw_n, input logic [7:0] data,
                               input string msg);
        @(posedge clk_bus_i);
        #1;
        pi_valid_i = 1'b1;
        pi_addr_i  = addr;
        pi_data_i  = data;
        pi_rw_ni   = rw_n;
        if (rw_n) begin
            host_exp = host_read_value(addr);
            host_msg = msg;
            host_chk = 1'b1;
        end else if (!addr[16]) begin
            shadow[addr[15:0]] = data;                // ROM space too
        end else if (addr[3:0] < 4'(pet_pkg::KBD_ROWS)) begin
            rows[addr[3:0]] = data;
        end else if (addr[3:0] == pet_pkg::REG_CTRL_OFFSET) begin
            ctrl = data;
        end
        @(posedge clk_bus_i);
        #1;
        pi_valid_i = 1'b0;
        do begin
            @(negedge clk_bus_i);
        end while (!pi_done_o);
        @(posedge clk_bus_i);
        #1;
        host_chk = 1'b0;                              // Comparator has seen the done cycle
    endtask

    // Drive one CPU cycle from phase 0 and check read data after the next phase 0
    task automatic cpu_access(input logic [15:0] addr, input logic rw_n, input logic [7:0] data,
                              input logic [7:0] io);
        logic [7:0] exp_rd;
        @(negedge clk_cpu_o);
        #1;
        cpu_addr_i = addr;
        cpu_rw_ni  = rw_n;
        cpu_data_i = data;
        io_data_i  = io;
        exp_rd     = cpu_read_value(addr, io);
        @(posedge clk_bus_i);
        #1;
        check_value({5'b0, pia1_cs_o, pia2_cs_o, via_cs_o}, 8'h00, "chip selects before phi2");
        @(posedge clk_cpu_o);
        #1;
        check_value({5'b0, pia1_cs_o, pia2_cs_o, via_cs_o},
                    {5'b0, chip_select_map(addr, rw_n)}, "chip selects during phi2");
        @(negedge clk_cpu_o);
        @(posedge clk_bus_i);
        #1;
        if (rw_n) begin
            check_value(cpu_data_o, exp_rd, "CPU read data");
        end else if ((addr & 16'hFFF0) == pet_pkg::PIA1_BASE && addr[1:0] == 2'd0) begin
            row_sel = data[3:0];                      // Port A picks the keyboard row
        end else if (addr < pet_pkg::ROM_BASE) begin
            shadow[vram_mirror(addr)] = data;
        end
        cpu_addr_i = 16'h0000;                        // Idle on a harmless RAM read
        cpu_rw_ni  = 1'b1;
    endtask

    initial begin
        clk_bus_i = 1'b0;
        forever begin
            #4 clk_bus_i = ~clk_bus_i;
        end
    end

    always @(posedge clk_bus_i) begin
        if (reset_i) begin
            phase <= 0;
        end else begin
            phase <= (phase + 1) % pet_pkg::CYCLE_PHASES;  // Eight phases per CPU cycle
        end
    end

    always @(negedge clk_bus_i) begin
        // Phi2 is high in phases 4 to 7
        if (!reset_i) begin
            check_value({7'b0, clk_cpu_o}, {7'b0, phase >= 4}, "clk_cpu_o in this phase");
        end
        if (pi_done_o) begin
            check_value(8'(phase), 8'd2, "phase of pi_done_o");
        end
        if (pi_done_o && host_chk) begin
            check_value(pi_rd_data_o, host_exp, host_msg);  // Host read data in the done cycle
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        seed       = 32'h6410;
        errors     = 0;
        checks     = 0;
        host_chk   = 1'b0;
        reset_i    = 1'b1;
        pi_valid_i = 1'b0;
        pi_addr_i  = '0;
        pi_data_i  = '0;
        pi_rw_ni   = 1'b1;
        cpu_addr_i = '0;
        cpu_rw_ni  = 1'b1;
        cpu_data_i = '0;
        io_data_i  = '0;
        ctrl       = 8'h01;                           // CPU held in reset and halted
        row_sel    = 4'd0;
        foreach (rows[i]) begin
            rows[i] = 8'hFF;                          // No key pressed
        end
        repeat (3) @(posedge clk_bus_i);
        #1;
        reset_i = 1'b0;

        check_value({7'b0, cpu_res_o}, 8'h01, "cpu_res_o after reset");
        check_value({7'b0, cpu_ready_o}, 8'h00, "cpu_ready_o after reset");
        host_access({1'b1, 12'h000, pet_pkg::REG_CTRL_OFFSET}, 1'b0, 8'h02, "");
        check_value({7'b0, cpu_res_o}, {7'b0, ctrl[0]}, "cpu_res_o after host write");
        check_value({7'b0, cpu_ready_o}, {7'b0, ctrl[1]}, "cpu_ready_o after host write");
        host_access({1'b1, 12'h000, pet_pkg::REG_CTRL_OFFSET}, 1'b1, 8'h00, "control readback");

        for (int i = 0; i < N_RAM; i++) begin
            addr = 16'($random(seed));
            data = 8'($random(seed));
            host_access({1'b0, addr}, 1'b0, data, "");
            host_access({1'b0, addr}, 1'b1, 8'h00, "host RAM readback");
        end

        for (int i = 0; i < N_CPU_RAM; i++) begin
            addr = 16'($random(seed)) & 16'h7FFF;     // Plain RAM below video
            cpu_access(addr, 1'b0, 8'($random(seed)), 8'h00);
            host_access({1'b0, addr}, 1'b1, 8'h00, "host read of CPU write");
            do begin
                addr = 16'($random(seed));
            end while (addr < pet_pkg::ROM_BASE || in_io(addr));
            data = 8'($random(seed));
            host_access({1'b0, addr}, 1'b0, data, "");
            cpu_access(addr, 1'b0, ~data, 8'h00);     // Must be dropped
            host_access({1'b0, addr}, 1'b1, 8'h00, "ROM after CPU write");
        end

        data = 8'($random(seed));
        cpu_access(16'h8C05, 1'b0, data, 8'h00);
        host_access({1'b0, 16'h8005}, 1'b1, 8'h00, "video RAM mirror from host");
        cpu_access(16'h8405, 1'b1, 8'h00, ~data);

        foreach (IO_ADDRS[i]) begin
            cpu_access(IO_ADDRS[i], 1'b1, 8'h00, 8'($random(seed)));
            cpu_access(IO_ADDRS[i], 1'b0, 8'($random(seed)), 8'h00);
        end

        for (int r = 0; r < pet_pkg::KBD_ROWS; r++) begin
            host_access({1'b1, 12'h000, 4'(r)}, 1'b0, 8'($random(seed)), "");
        end
        for (int s = 0; s < N_SEL; s++) begin
            cpu_access(pet_pkg::PIA1_BASE, 1'b0, {4'($random(seed)), 4'(s)}, 8'h00);
            cpu_access(pet_pkg::PIA1_BASE + 16'd2, 1'b1, 8'h00, 8'($random(seed)));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
